// File: rtl/bus_pkg.sv
/*
 * Tile bus definitions
 * Widths, word-address map and target select for the single-master
 * Wishbone fabric of the tile.
 */
package bus_pkg;

	localparam int DATA_W = 32;	// bus data width
	localparam int ADR_W = 30;	// word address, byte bits 31..2
	localparam int SEL_W = 4;	// one select bit per byte lane
	localparam int RAM_AW = 8;	// 256 word program ram

	// word address map
	localparam logic [ADR_W-1:0] RAM_BASE = '0;	// bytes 0x000..0x3ff
	localparam logic [ADR_W-1:0] GPIO_BASE = 'h400;	// byte 0x1000, 8 words

	// decoded target of the current cycle
	typedef enum logic [1:0] {
		SLV_RAM,	// program ram
		SLV_GPIO,	// output port bank
		SLV_NONE	// unmapped, decoder answers
	} slave_e;

endpackage

// File: rtl/gpio_pkg.sv
/*
 * Output port layout
 * Eight 7-bit ports, one per word, packed side by side on the output.
 */
package gpio_pkg;

	localparam int PORT_NUM = 8;	// seven segment style ports
	localparam int PORT_W = 7;	// bits per port
	localparam int PORT_AW = 3;	// port index from low word addr bits

	// port k sits at bits 7k+6..7k of the output vector
	localparam int GPIO_W = PORT_NUM * PORT_W;

endpackage

// File: rtl/wb_slave_if.sv
/*
 * Wishbone slave link
 * Classic single-cycle handshake between the decoder and one slave.
 */
interface wb_slave_if;

	logic stb;	// gated strobe, one slave at a time
	logic we;	// write enable
	logic [bus_pkg::SEL_W-1:0] sel;	// byte lanes
	logic [bus_pkg::ADR_W-1:0] adr;	// word address
	logic [bus_pkg::DATA_W-1:0] wdat;	// write data
	logic [bus_pkg::DATA_W-1:0] rdat;	// read data, valid with ack
	logic ack;	// single-cycle pulse

	// decoder side
	modport master (
		output stb, we, sel, adr, wdat,
		input rdat, ack
	);

	// ram and port bank side
	modport slave (
		input stb, we, sel, adr, wdat,
		output rdat, ack
	);

endinterface

// File: rtl/wb_bus_decoder.sv
/*
 * Wishbone address decoder
 * Routes the master strobe to one slave, merges read data and acks,
 * and answers unmapped addresses itself after one cycle.
 */
module wb_bus_decoder (
	input logic clk,
	input logic arst_n_i,
	input logic [bus_pkg::ADR_W-1:0] cpu_adr_i,
	input logic cpu_stb_i,
	input logic cpu_we_i,
	input logic [bus_pkg::SEL_W-1:0] cpu_sel_i,
	input logic [bus_pkg::DATA_W-1:0] cpu_dat_i,
	output logic cpu_ack_o,
	output logic [bus_pkg::DATA_W-1:0] cpu_dat_o,
	wb_slave_if.master ram_bus,
	wb_slave_if.master gpio_bus
);

	logic ram_hit;	// address inside ram window
	logic gpio_hit;	// address inside port window
	bus_pkg::slave_e slv;	// decoded target
	logic none_ack;	// ack for unmapped accesses

	// upper word-address bits must match the region base
	assign ram_hit = (cpu_adr_i[bus_pkg::ADR_W-1:bus_pkg::RAM_AW] ==
		bus_pkg::RAM_BASE[bus_pkg::ADR_W-1:bus_pkg::RAM_AW]);
	assign gpio_hit = (cpu_adr_i[bus_pkg::ADR_W-1:gpio_pkg::PORT_AW] ==
		bus_pkg::GPIO_BASE[bus_pkg::ADR_W-1:gpio_pkg::PORT_AW]);

	always_comb begin
		if (ram_hit)
			slv = bus_pkg::SLV_RAM;
		else if (gpio_hit)
			slv = bus_pkg::SLV_GPIO;
		else
			slv = bus_pkg::SLV_NONE;	// nobody home
	end

	// strobe goes to exactly one slave
	assign ram_bus.stb = cpu_stb_i && (slv == bus_pkg::SLV_RAM);
	assign gpio_bus.stb = cpu_stb_i && (slv == bus_pkg::SLV_GPIO);

	// shared payload, slaves keep only the low bits they need
	assign ram_bus.we = cpu_we_i;
	assign ram_bus.sel = cpu_sel_i;
	assign ram_bus.adr = cpu_adr_i;
	assign ram_bus.wdat = cpu_dat_i;
	assign gpio_bus.we = cpu_we_i;
	assign gpio_bus.sel = cpu_sel_i;
	assign gpio_bus.adr = cpu_adr_i;
	assign gpio_bus.wdat = cpu_dat_i;

	// unmapped access acked with the same latency as a slave
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			none_ack <= 1'b0;
		else
			none_ack <= cpu_stb_i && (slv == bus_pkg::SLV_NONE) && !none_ack;
	end

	assign cpu_ack_o = ram_bus.ack | gpio_bus.ack | none_ack;

	// address is held until ack, so slv still points at the source
	always_comb begin
		case (slv)
			bus_pkg::SLV_RAM: cpu_dat_o = ram_bus.rdat;
			bus_pkg::SLV_GPIO: cpu_dat_o = gpio_bus.rdat;
			default: cpu_dat_o = '0;	// unmapped reads as zero
		endcase
	end

endmodule

// File: rtl/prog_ram.sv
/*
 * Program RAM
 * 256 words with per-byte write lanes; read word and ack come back
 * one cycle after the strobe.
 */
module prog_ram (
	input logic clk,
	input logic arst_n_i,
	wb_slave_if.slave bus
);

	logic [bus_pkg::DATA_W-1:0] mem [2**bus_pkg::RAM_AW];	// word storage
	logic [bus_pkg::RAM_AW-1:0] idx;	// word index
	logic access;	// first cycle of a strobe

	assign idx = bus.adr[bus_pkg::RAM_AW-1:0];	// decoder did the range check
	assign access = bus.stb && !bus.ack;

	// ack pulse, one per transaction
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= access;
	end

	// storage and read register
	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we) begin
				for (int b = 0; b < bus_pkg::SEL_W; b++) begin
					if (bus.sel[b])	// only enabled lanes
						mem[idx][b*(bus_pkg::DATA_W/bus_pkg::SEL_W) +:
							bus_pkg::DATA_W/bus_pkg::SEL_W] <=
							bus.wdat[b*(bus_pkg::DATA_W/bus_pkg::SEL_W) +:
							bus_pkg::DATA_W/bus_pkg::SEL_W];
				end
			end
			bus.rdat <= mem[idx];	// old word on writes
		end
	end

endmodule

// File: rtl/gpio_port.sv
/*
 * Output port bank
 * Eight 7-bit registers driven straight onto the output pins,
 * written through byte lane 0 and readable over the bus.
 */
module gpio_port (
	input logic clk,
	input logic arst_n_i,
	wb_slave_if.slave bus,
	output logic [gpio_pkg::GPIO_W-1:0] gpio_o
);

	logic [gpio_pkg::PORT_W-1:0] port_q [gpio_pkg::PORT_NUM];	// port registers
	logic [gpio_pkg::PORT_AW-1:0] idx;	// selected port
	logic access;	// first cycle of a strobe

	assign idx = bus.adr[gpio_pkg::PORT_AW-1:0];
	assign access = bus.stb && !bus.ack;

	// ack pulse and port registers
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bus.ack <= 1'b0;
			for (int k = 0; k < gpio_pkg::PORT_NUM; k++)
				port_q[k] <= '0;	// all segments dark
		end else begin
			bus.ack <= access;
			if (access && bus.we && bus.sel[0])	// lane 0 carries the port bits
				port_q[idx] <= bus.wdat[gpio_pkg::PORT_W-1:0];
		end
	end

	// zero extended readback of the selected port
	always_ff @(posedge clk) begin
		if (access)
			bus.rdat <= {{(bus_pkg::DATA_W-gpio_pkg::PORT_W){1'b0}}, port_q[idx]};
	end

	// port k on bits 7k+6..7k
	always_comb begin
		for (int k = 0; k < gpio_pkg::PORT_NUM; k++)
			gpio_o[k*gpio_pkg::PORT_W +: gpio_pkg::PORT_W] = port_q[k];
	end

endmodule

// File: rtl/tile_top.sv
/*
 * Processor tile bus
 * External master on the cpu data port, decoded onto program RAM
 * and the output port bank.
 */
module tile_top (
	input logic clk,
	input logic arst_n_i,
	input logic [bus_pkg::ADR_W-1:0] cpu_adr_i,	// word address
	input logic cpu_stb_i,
	input logic cpu_we_i,
	input logic [bus_pkg::SEL_W-1:0] cpu_sel_i,
	input logic [bus_pkg::DATA_W-1:0] cpu_dat_i,
	output logic cpu_ack_o,
	output logic [bus_pkg::DATA_W-1:0] cpu_dat_o,
	output logic [gpio_pkg::GPIO_W-1:0] gpio_o	// eight 7-bit ports
);

	wb_slave_if ram_bus ();	// decoder to ram
	wb_slave_if gpio_bus ();	// decoder to port bank

	wb_bus_decoder the_bus (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.cpu_adr_i(cpu_adr_i),
		.cpu_stb_i(cpu_stb_i),
		.cpu_we_i(cpu_we_i),
		.cpu_sel_i(cpu_sel_i),
		.cpu_dat_i(cpu_dat_i),
		.cpu_ack_o(cpu_ack_o),
		.cpu_dat_o(cpu_dat_o),
		.ram_bus(ram_bus),
		.gpio_bus(gpio_bus)
	);

	prog_ram the_ram (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.bus(ram_bus)
	);

	gpio_port the_gpio (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.bus(gpio_bus),
		.gpio_o(gpio_o)
	);

endmodule

// File: testbench/tb_tile.sv
/*
 * Testbench for the tile bus
 * Replays a file of bus writes, reads and port checks on the master
 * port, checking read data, ack latency and the output port vector.
 */
module tb_tile;

	typedef struct packed {
		logic [7:0] op;	// W write, R read, G port check
		logic [31:0] adr;	// byte address
		logic [3:0] sel;	// byte lanes
		logic [31:0] dat;	// write data
		logic [63:0] want;	// read data or whole port vector
	} stim_t;

	localparam int PERIOD = 10;	// clock period
	localparam int ACK_WAIT = 4;	// max cycles from strobe to ack
	localparam logic [15:0] LFSR_SEED = 16'd85;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;	// x^16+x^14+x^13+x^11+1

	logic clk;
	logic arst_n_i;
	logic [bus_pkg::ADR_W-1:0] cpu_adr_i;	// word address
	logic cpu_stb_i;
	logic cpu_we_i;
	logic [bus_pkg::SEL_W-1:0] cpu_sel_i;
	logic [bus_pkg::DATA_W-1:0] cpu_dat_i;
	logic cpu_ack_o;
	logic [bus_pkg::DATA_W-1:0] cpu_dat_o;
	logic [gpio_pkg::GPIO_W-1:0] gpio_o;

	stim_t stim_q[$];	// every line of the input file
	logic [15:0] lfsr;	// idle gap source
	bit loaded;	// starts the watchdog
	int lines_done;

	tile_top i_dut (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.cpu_adr_i(cpu_adr_i),
		.cpu_stb_i(cpu_stb_i),
		.cpu_we_i(cpu_we_i),
		.cpu_sel_i(cpu_sel_i),
		.cpu_dat_i(cpu_dat_i),
		.cpu_ack_o(cpu_ack_o),
		.cpu_dat_o(cpu_dat_o),
		.gpio_o(gpio_o)
	);

	always #(PERIOD/2) clk = ~clk;

	// prints the reason and ends the run
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h",
				name, actual, expected));
	endtask

	// galois step shifting right with taps folded in on a one
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		else
			return s >> 1;
	endfunction

	// two bits taken one step each give 1 to 4 idle cycles
	task automatic draw_gap(output int gap);
		logic [1:0] pick;
		lfsr = lfsr_next(lfsr);
		pick[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		pick[1] = lfsr[0];
		gap = 1 + int'(pick);
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		int line_no;
		string text;
		logic [7:0] op;
		logic [31:0] adr;
		logic [3:0] sel;
		logic [31:0] dat;
		logic [63:0] want;
		fd = $fopen("testbench/tile_input.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file testbench/tile_input.txt");
		line_no = 0;
		while ($fgets(text, fd) != 0) begin
			line_no++;
			if (text.len() < 2 || text.getc(0) == "#")	// blank or comment
				continue;
			n = $sscanf(text, "%c %h %h %h %h", op, adr, sel, dat, want);
			if (n != 5)
				abort_run($sformatf("stimulus line %0d is malformed", line_no));
			stim_q.push_back('{op: op, adr: adr, sel: sel, dat: dat, want: want});
		end
		$fclose(fd);
	endtask

	// one read or write with strobe held until ack
	task automatic bus_cycle(input stim_t s);
		int gap;
		int cycles;
		draw_gap(gap);
		repeat (gap) @(posedge clk);
		#1;
		cpu_adr_i = s.adr[31:2];	// byte to word address
		cpu_we_i = (s.op == "W");
		cpu_sel_i = s.sel;
		cpu_dat_i = s.dat;
		cpu_stb_i = 1'b1;
		#1;
		check_value("cpu_ack_o", 64'(cpu_ack_o), 64'd0);	// no ack before the edge
		cycles = 0;
		do begin
			@(posedge clk);
			#1;	// ack and data are settled here
			cycles++;
		end while (!cpu_ack_o && cycles < ACK_WAIT);
		if (!cpu_ack_o)
			abort_run($sformatf("no acknowledge from bus at byte address 0x%h",
				s.adr));
		check_value("ack latency", 64'(cycles), 64'd1);	// always one cycle
		if (s.op == "R")
			check_value("cpu_dat_o", 64'(cpu_dat_o), s.want);
		cpu_stb_i = 1'b0;	// drop in the cycle after ack
		cpu_we_i = 1'b0;
	endtask

	// whole vector so untouched ports are covered too
	task automatic check_ports(input stim_t s);
		check_value("gpio_o", 64'(gpio_o), s.want);
	endtask

	initial begin
		clk = 1'b0;
		arst_n_i = 1'b0;
		cpu_adr_i = '0;
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_sel_i = '0;
		cpu_dat_i = '0;
		lfsr = LFSR_SEED;
		lines_done = 0;
		load_stimulus();
		loaded = 1'b1;

		repeat (2) @(posedge clk);	// two cycles in reset
		#1;
		arst_n_i = 1'b1;
		check_value("gpio_o", 64'(gpio_o), 64'd0);	// all ports dark
		check_value("cpu_ack_o", 64'(cpu_ack_o), 64'd0);

		foreach (stim_q[i]) begin
			case (stim_q[i].op)
				"W", "R": bus_cycle(stim_q[i]);
				"G": check_ports(stim_q[i]);
				default: abort_run($sformatf("unknown operation %c in stimulus entry %0d",
					stim_q[i].op, i));
			endcase
			lines_done++;
		end

		if (lines_done == 0) begin
			abort_run("the stimulus file held no operations");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

	// bound from the number of lines with room for reset
	initial begin
		wait (loaded);
		repeat (stim_q.size() * 10 + 50) @(posedge clk);
		abort_run("simulation timed out");
	end

endmodule

// File: testbench/tile_input.txt
# columns: op (W write, R read, G port check), byte address, sel, data, expected
# expected is read data for R and the 56-bit gpio_o vector for G, unused for W
# reset state of the ports
G 0 0 00000000 00000000000000
# full words into ram, read back after all writes
W 000 F DEADBEEF 0
W 004 F 12345678 0
W 3FC F CAFEF00D 0
W 100 F A5A5A5A5 0
R 000 F 00000000 DEADBEEF
R 004 F 00000000 12345678
R 3FC F 00000000 CAFEF00D
R 100 F 00000000 A5A5A5A5
# byte lanes over words that already hold data
W 004 1 000000AA 0
R 004 F 00000000 123456AA
W 004 C 99880000 0
R 004 F 00000000 998856AA
W 000 6 00BBCC00 0
R 000 F 00000000 DEBBCCEF
W 100 8 11000000 0
R 100 F 00000000 11A5A5A5
W 3FC 0 FFFFFFFF 0
R 3FC F 00000000 CAFEF00D
# output ports, one port per word from 0x1000
W 1000 1 0000007F 0
G 0 0 00000000 0000000000007F
W 1008 1 00000055 0
G 0 0 00000000 0000000015407F
W 101C 1 0000002A 0
G 0 0 00000000 5400000015407F
W 1004 1 FFFFFF83 0
G 0 0 00000000 540000001541FF
# lane 0 clear leaves the port alone
W 1000 E 00000011 0
G 0 0 00000000 540000001541FF
R 1000 F 00000000 0000007F
R 1004 F 00000000 00000003
R 1008 F 00000000 00000055
R 101C F 00000000 0000002A
R 1010 F 00000000 00000000
W 1000 F 00000000 0
G 0 0 00000000 54000000154180
W 100C 1 00000001 0
W 1018 1 00000040 0
G 0 0 00000000 55000000354180
R 100C F 00000000 00000001
R 1018 F 00000000 00000040
# unmapped addresses are acked, read zero, touch nothing
W 2000 F FFFFFFFF 0
R 2000 F 00000000 00000000
W 400 F 12121212 0
R 400 F 00000000 00000000
W 1020 1 0000007F 0
R 1020 F 00000000 00000000
W FFFFFFFC F 5A5A5A5A 0
R FFFFFFFC F 00000000 00000000
G 0 0 00000000 55000000354180
R 000 F 00000000 DEBBCCEF
R 1000 F 00000000 00000000
R 004 F 00000000 998856AA
G 0 0 00000000 55000000354180

// File: vlog.f
// packages first, then the interface they feed
rtl/bus_pkg.sv
rtl/gpio_pkg.sv
rtl/wb_slave_if.sv
// design
rtl/wb_bus_decoder.sv
rtl/prog_ram.sv
rtl/gpio_port.sv
rtl/tile_top.sv
// testbench
testbench/tb_tile.sv

// File: run_sim.sh
#!/bin/sh
# Build the tile bus testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_tile \
	-f vlog.f \
	-Mdir obj_dir \
	-o tb_tile

./obj_dir/tb_tile
